// ==== logic/actBus.sv ====
`timescale 1ns/1ps

interface actBus;

	import nnPkg::*;

	logic vecValid; // Pulses for one cycle per vector.
	actVectorT act; // Stable while the layer works on it.

	// The gatherer drives the vector.
	modport source
	(
		output vecValid,
		output act
	);

	// The layer reads it.
	modport sink
	(
		input vecValid,
		input act
	);

endinterface

// ==== logic/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer
#(
	parameter int NODE_COUNT = nnPkg::NUM_NODES,
	parameter nnPkg::weightRowT [NODE_COUNT-1:0] WEIGHTS = '0,
	parameter nnPkg::weightT [NODE_COUNT-1:0] BIASES = '0
)
(
	input logic clk,
	input logic reset,
	actBus.sink vecIn,
	output logic resVecValid,
	output nnPkg::activationT [NODE_COUNT-1:0] resVec,
	output logic layerBusy
);

	logic [2:0] validPipe; // Tracks the node latency of three edges.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], vecIn.vecValid};
		end
	end

	assign resVecValid = validPipe[2];
	assign layerBusy = |validPipe;

	// ~~~~~~~~~~~~~~~~~~~~
	// One node per output word, all reading the same vector.
	for (genvar g = 0; g < NODE_COUNT; g++)
	begin : nodeGen
		neuronNode
		#(
			.NODE_WEIGHTS(WEIGHTS[g]),
			.NODE_BIAS(BIASES[g])
		)
		nodeInst
		(
			.clk(clk),
			.reset(reset),
			.act(vecIn.act),
			.result(resVec[g])
		);
	end

	// The gatherer holds back until the pipe drains, so stages never overlap.
	assert property (@(posedge clk) disable iff (reset) $onehot0(validPipe));

endmodule

// ==== logic/inputGather.sv ====
`timescale 1ns/1ps

module inputGather
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::activationT inData,
	output logic inReady,
	input logic layerBusy,
	input logic holding,
	actBus.source vecOut
);

	import nnPkg::*;

	inputIndexT wordIdx;
	actVectorT vecReg;
	logic waitFlag;
	logic vecValidReg;
	logic accept;
	logic lastWord;
	logic downstreamFree;

	assign inReady = ~waitFlag;
	assign accept = inValid && inReady; // Handshake on this edge.
	assign lastWord = (wordIdx == inputIndexT'(NUM_INPUTS - 1));
	// The pulse itself counts as busy, as the layer only sees it on the next edge.
	assign downstreamFree = !vecValidReg && !layerBusy && !holding;

	assign vecOut.vecValid = vecValidReg;
	assign vecOut.act = vecReg; // Held still while waitFlag is set.

	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			vecReg[wordIdx] <= inData;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wordIdx <= '0;
			waitFlag <= 1'b0;
			vecValidReg <= 1'b0;
		end
		else
		begin
			vecValidReg <= accept && lastWord; // One pulse per full vector.
			if (accept)
			begin
				wordIdx <= lastWord ? '0 : wordIdx + 1'b1;
			end
			if (accept && lastWord)
			begin
				waitFlag <= 1'b1;
			end
			else if (downstreamFree)
			begin
				waitFlag <= 1'b0; // Results of the last vector are all gone.
			end
		end
	end

	// A new vector must never land on a layer that is still working.
	assert property (@(posedge clk) disable iff (reset) vecOut.vecValid |-> !layerBusy);

endmodule

// ==== logic/neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode
#(
	parameter nnPkg::weightRowT NODE_WEIGHTS = '0,
	parameter nnPkg::weightT NODE_BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input nnPkg::actVectorT act,
	output nnPkg::activationT result
);

	import nnPkg::*;

	actVectorT actReg;
	activationT sumComb;
	activationT sumReg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Multiply-accumulate
	// Each product keeps only its low word, and the sum wraps.
	always_comb
	begin
		sumComb = NODE_BIAS;
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			sumComb = sumComb + activationT'(actReg[i] * NODE_WEIGHTS[i]);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Three register stages.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= act; // Stage 1.
			sumReg <= sumComb; // Stage 2.
			if (sumReg[WORD_WIDTH-1] == 1'b0)
			begin
				result <= sumReg; // Stage 3, ReLU.
			end
			else
			begin
				result <= '0;
			end
		end
	end

endmodule

// ==== logic/nnLayerTop.sv ====
`timescale 1ns/1ps

module nnLayerTop
#(
	parameter int NODE_COUNT = nnPkg::NUM_NODES,
	parameter nnPkg::weightRowT [NODE_COUNT-1:0] WEIGHTS = '0,
	parameter nnPkg::weightT [NODE_COUNT-1:0] BIASES = '0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::activationT inData,
	output logic inReady,
	output logic outValid,
	output nnPkg::activationT outData,
	input logic outReady
);

	import nnPkg::*;

	logic layerBusy;
	logic holding;
	logic resVecValid;
	activationT [NODE_COUNT-1:0] resVec;

	actBus actBusInst ();

	inputGather gatherInst
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inReady(inReady),
		.layerBusy(layerBusy),
		.holding(holding),
		.vecOut(actBusInst.source)
	);

	denseLayer
	#(
		.NODE_COUNT(NODE_COUNT),
		.WEIGHTS(WEIGHTS),
		.BIASES(BIASES)
	)
	layerInst
	(
		.clk(clk),
		.reset(reset),
		.vecIn(actBusInst.sink),
		.resVecValid(resVecValid),
		.resVec(resVec),
		.layerBusy(layerBusy)
	);

	outputSerializer #(.NODE_COUNT(NODE_COUNT)) serialInst
	(
		.clk(clk),
		.reset(reset),
		.resVecValid(resVecValid),
		.resVec(resVec),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady),
		.holding(holding)
	);

endmodule

// ==== logic/nnPkg.sv ====
package nnPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Layer dimensions.
	parameter int NUM_INPUTS = 15; // Activations per input vector.
	parameter int NUM_NODES = 4; // Default node count of one layer.
	parameter int WORD_WIDTH = 16; // Fixed-point word width.

	// ~~~~~~~~~~~~~~~~~~~~
	// Word types.
	typedef logic signed [WORD_WIDTH-1:0] activationT; // Also carries node results.
	typedef logic signed [WORD_WIDTH-1:0] weightT; // Weight or bias.

	// ~~~~~~~~~~~~~~~~~~~~
	// Array types.
	typedef activationT [NUM_INPUTS-1:0] actVectorT; // Element 0 is the first word streamed in.
	typedef weightT [NUM_INPUTS-1:0] weightRowT; // One row per node.

	typedef logic [$clog2(NUM_INPUTS)-1:0] inputIndexT; // Counts 0 to NUM_INPUTS-1.

endpackage

// ==== logic/outputSerializer.sv ====
`timescale 1ns/1ps

module outputSerializer
#(
	parameter int NODE_COUNT = nnPkg::NUM_NODES
)
(
	input logic clk,
	input logic reset,
	input logic resVecValid,
	input nnPkg::activationT [NODE_COUNT-1:0] resVec,
	output logic outValid,
	output nnPkg::activationT outData,
	input logic outReady,
	output logic holding
);

	import nnPkg::*;

	localparam int IDX_WIDTH = (NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1;

	activationT [NODE_COUNT-1:0] resBuf;
	logic [IDX_WIDTH-1:0] nodeIdx;
	logic busyReg;
	logic transfer;
	logic lastNode;

	assign outValid = busyReg;
	assign holding = busyReg; // Unsent words remain in the buffer.
	assign outData = resBuf[nodeIdx];
	assign transfer = busyReg && outReady;
	assign lastNode = (nodeIdx == IDX_WIDTH'(NODE_COUNT - 1));

	always_ff @(posedge clk)
	begin
		if (resVecValid)
		begin
			resBuf <= resVec;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busyReg <= 1'b0;
			nodeIdx <= '0;
		end
		else if (resVecValid)
		begin
			busyReg <= 1'b1;
			nodeIdx <= '0; // Node 0 goes out first.
		end
		else if (transfer)
		begin
			busyReg <= !lastNode;
			nodeIdx <= lastNode ? '0 : nodeIdx + 1'b1;
		end
	end

	// A fresh result vector would overwrite words not yet sent.
	assert property (@(posedge clk) disable iff (reset) resVecValid |-> !holding);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module nnLayerTb \
	-o nnLayerSim \
	-f vlog.f

./obj_dir/nnLayerSim | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log
then
	echo "Simulation passed."
else
	echo "Simulation failed."
	exit 1
fi

// ==== tb/nnLayerTb.sv ====
`timescale 1ns/1ps

module nnLayerTb;

	import nnPkg::*;

	// ~~~~~~~~~~~~~~~~~~~~
	// Test sizes.
	localparam int NODE_COUNT = 4;
	localparam int NUM_VECTORS = 40;
	localparam int TIMEOUT_CYCLES = NUM_VECTORS * (NUM_INPUTS + 4 + NODE_COUNT) * 4 + 200;
	localparam int RESULT_LATENCY = 5; // Sampling edges from the last input word to outValid.

	// Weight rows with element 0 meeting the first streamed word.
	localparam int WEIGHT_TABLE [NODE_COUNT][NUM_INPUTS] = '{
		'{9, 7, 9, 8, 5, 3, 5, 6, 2, 9, 5, 1, 4, 1, 3},
		'{-3, 0, 9, 5, 4, 8, 2, 8, 1, 8, 2, 8, 1, 7, 2},
		'{-2, 3, 7, 3, -7, 2, 6, 5, 3, 1, 2, 4, 1, 4, 1},
		'{3, 3, 5, 1, 0, 9, 4, 6, 6, 5, 1, 2, 7, 7, 5}
	};
	localparam int BIAS_TABLE [NODE_COUNT] = '{100, 0, 37, -500}; // Node 3 starts below zero.

	typedef weightRowT [NODE_COUNT-1:0] weightTableT;
	typedef weightT [NODE_COUNT-1:0] biasTableT;

	function automatic weightTableT buildWeights();
		weightTableT rows;
		for (int n = 0; n < NODE_COUNT; n++)
		begin
			for (int i = 0; i < NUM_INPUTS; i++)
			begin
				rows[n][i] = weightT'(WEIGHT_TABLE[n][i]);
			end
		end
		return rows;
	endfunction

	function automatic biasTableT buildBiases();
		biasTableT biases;
		for (int n = 0; n < NODE_COUNT; n++)
		begin
			biases[n] = weightT'(BIAS_TABLE[n]);
		end
		return biases;
	endfunction

	localparam weightTableT WEIGHTS = buildWeights();
	localparam biasTableT BIASES = buildBiases();

	// ~~~~~~~~~~~~~~~~~~~~
	// DUT signals.
	logic clk;
	logic reset;
	logic inValid;
	activationT inData;
	logic inReady;
	logic outValid;
	activationT outData;
	logic outReady;

	// Stimulus, model and monitor state.
	int seed;
	actVectorT vectors [NUM_VECTORS];
	activationT expQ [$];
	bit readyPattern [TIMEOUT_CYCLES];
	int cycleCount;
	int wordErrors = 0;
	int flagErrors = 0;
	int protocolErrors = 0;
	int zeroCount = 0;
	int inCount = 0;
	int outCount = 0;
	bit vecPending = 1'b0;
	int latencyCount = 0;
	bit prevStall = 1'b0;
	activationT prevData;
	activationT expWord;

	tbClock #(.PERIOD_NS(4)) clockInst
	(
		.clk(clk)
	);

	nnLayerTop
	#(
		.NODE_COUNT(NODE_COUNT),
		.WEIGHTS(WEIGHTS),
		.BIASES(BIASES)
	)
	nnLayerTop_inst
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inReady(inReady),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// Only the low word of the exact sum matters, as each step wraps modulo 2^16.
	function automatic activationT modelNode(input actVectorT vec, input int node);
		longint acc;
		activationT wrapped;
		acc = longint'(BIAS_TABLE[node]);
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			acc = acc + longint'(vec[i]) * longint'(WEIGHT_TABLE[node][i]);
		end
		wrapped = activationT'(acc[WORD_WIDTH-1:0]);
		if (wrapped < 0)
		begin
			return '0; // ReLU.
		end
		return wrapped;
	endfunction

	task automatic checkWord(input activationT actual, input activationT expected,
		input string what);
		if (actual !== expected)
		begin
			wordErrors++;
			$display("ERR at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic checkFlag(input logic actual, input logic expected, input string what);
		if (actual !== expected)
		begin
			flagErrors++;
			$display("ERR at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	// Draws the ready pattern and every vector, and queues the model's results.
	task automatic buildStimulus();
		activationT res;
		for (int c = 0; c < TIMEOUT_CYCLES; c++)
		begin
			readyPattern[c] = ($random(seed) & 1) == 1; // About half the cycles are ready.
		end
		for (int v = 0; v < NUM_VECTORS; v++)
		begin
			for (int i = 0; i < NUM_INPUTS; i++)
			begin
				if (v == 0 || v == NUM_VECTORS / 2)
				begin
					vectors[v][i] = '0; // Result is the bias alone.
				end
				else if (v % 8 == 5)
				begin
					vectors[v][i] = activationT'($random(seed)); // Full range to force wraps.
				end
				else
				begin
					vectors[v][i] = activationT'($random(seed) % 256);
				end
			end
			for (int n = 0; n < NODE_COUNT; n++)
			begin
				res = modelNode(vectors[v], n);
				if (res == 0)
				begin
					zeroCount++;
				end
				expQ.push_back(res);
			end
		end
		$display("Model expects %0d zero results out of %0d.", zeroCount, expQ.size());
	endtask

	// Offers one word after a random gap and holds it until accepted.
	task automatic sendWord(input activationT word);
		while (($random(seed) & 3) == 0)
		begin
			inValid <= 1'b0;
			@(posedge clk);
		end
		inValid <= 1'b1;
		inData <= word;
		@(posedge clk);
		while (!inReady)
		begin
			@(posedge clk);
		end
	endtask

	task automatic finishRun(input bit timedOut);
		if (expQ.size() != 0)
		begin
			protocolErrors++;
			$display("%0d expected result words never came out of the DUT.", expQ.size());
		end
		$display("Errors: %0d word, %0d flag, %0d protocol.", wordErrors, flagErrors,
			protocolErrors);
		if (!timedOut && wordErrors + flagErrors + protocolErrors == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Main stimulus.
	initial
	begin
		seed = 32'h9d3165bc;
		reset <= 1'b1;
		inValid <= 1'b0;
		inData <= '0;
		buildStimulus();
		repeat (8)
		begin
			@(posedge clk);
		end
		reset <= 1'b0;
		@(posedge clk);
		checkFlag(inReady, 1'b1, "inReady after reset");
		checkFlag(outValid, 1'b0, "outValid after reset");
		for (int v = 0; v < NUM_VECTORS; v++)
		begin
			for (int i = 0; i < NUM_INPUTS; i++)
			begin
				sendWord(vectors[v][i]);
			end
		end
		inValid <= 1'b0;
		while (expQ.size() != 0)
		begin
			@(posedge clk);
		end
		repeat (20)
		begin
			@(posedge clk); // Any extra word shows up here.
		end
		finishRun(1'b0);
	end

	// Output ready pattern and the cycle limit.
	initial
	begin
		cycleCount = 0;
		outReady <= 1'b0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			outReady <= readyPattern[cycleCount];
			cycleCount++;
		end
		$display("Timeout: the run did not end within %0d cycles.", TIMEOUT_CYCLES);
		finishRun(1'b1);
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Monitor. Values read here are the ones that decide this edge's transfers.
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (vecPending)
			begin
				checkFlag(inReady, 1'b0, "inReady while a vector is in flight");
			end
			if (latencyCount > 0)
			begin
				if (latencyCount < RESULT_LATENCY)
				begin
					checkFlag(outValid, 1'b0, "outValid before the result latency");
					latencyCount++;
				end
				else
				begin
					checkFlag(outValid, 1'b1, "outValid at the result latency");
					latencyCount = 0;
				end
			end
			if (prevStall)
			begin
				checkFlag(outValid, 1'b1, "outValid under back-pressure");
				checkWord(outData, prevData, "outData under back-pressure");
			end
			if (inValid && inReady)
			begin
				if (inCount % NUM_INPUTS == NUM_INPUTS - 1)
				begin
					vecPending = 1'b1; // Last word of a vector.
					latencyCount = 1;
				end
				inCount++;
			end
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					protocolErrors++;
					$display("An output word came out after all expected words were received.");
				end
				else
				begin
					expWord = expQ.pop_front();
					checkWord(outData, expWord, $sformatf("result word %0d", outCount));
				end
				if (outCount % NODE_COUNT == NODE_COUNT - 1)
				begin
					vecPending = 1'b0;
				end
				outCount++;
			end
			prevStall = outValid && !outReady;
			prevData = outData;
		end
	end

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/1ps

module tbClock
#(
	parameter int PERIOD_NS = 4
)
(
	output logic clk
);

	// ~~~~~~~~~~~~~~~~~~~~
	// Free-running clock that starts low.
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2);
			clk = ~clk; // Half a period per phase.
		end
	end

endmodule

// ==== vlog.f ====
logic/nnPkg.sv
logic/actBus.sv
logic/inputGather.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/outputSerializer.sv
logic/nnLayerTop.sv
tb/tbClock.sv
tb/nnLayerTb.sv
